//--- project.f
design/paging_pkg.sv
design/mmu_pkg.sv
design/tlb_cache.sv
design/page_walker.sv
design/access_control.sv
design/mmu_top.sv
test/tb_page_memory.sv
test/tb_mmu.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu -f project.f \
    -o tb_mmu_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/tb_mmu_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

//--- test/tb_mmu.sv
// Rows share TLB state and run in order; page layout and cr3 match tb_page_memory
module tb_mmu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_ROWS        = 14;
    localparam int ROW_LIMIT       = 40;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 60 + RESET_CYCLES;

    // One request and its expected outcome
    typedef struct packed {
        logic        paging;
        logic        wp;
        logic        flush;
        logic [31:0] address;
        logic [1:0]  cpl;
        logic        rmw;
        logic        fault;
        logic [15:0] error;
        logic [3:0]  reads;
        logic [31:0] phys;
    } test_row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        paging;
    logic        write_protect;
    logic [31:0] cr3;
    logic        flush_all;
    logic        read_do;
    logic [1:0]  read_cpl;
    logic        read_rmw;
    logic [31:0] read_address;
    logic        read_done;
    logic        read_page_fault;
    logic [63:0] read_data;
    logic [31:0] fault_address;
    logic [15:0] fault_error;
    logic        mem_read_do;
    logic [31:0] mem_read_address;
    logic        mem_read_done;
    logic [63:0] mem_read_data;
    logic [31:0] read_count;

    test_row_t   rows [NUM_ROWS];
    int          error_count = 0;
    int          rows_failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mmu_top #(
        .TLB_ENTRIES (4)
    ) dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .paging           (paging),
        .write_protect    (write_protect),
        .cr3              (cr3),
        .flush_all        (flush_all),
        .read_do          (read_do),
        .read_cpl         (read_cpl),
        .read_rmw         (read_rmw),
        .read_address     (read_address),
        .read_done        (read_done),
        .read_page_fault  (read_page_fault),
        .read_data        (read_data),
        .fault_address    (fault_address),
        .fault_error      (fault_error),
        .mem_read_do      (mem_read_do),
        .mem_read_address (mem_read_address),
        .mem_read_done    (mem_read_done),
        .mem_read_data    (mem_read_data)
    );

    tb_page_memory page_memory (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_read_do      (mem_read_do),
        .mem_read_address (mem_read_address),
        .mem_read_done    (mem_read_done),
        .mem_read_data    (mem_read_data),
        .read_count       (read_count)
    );

    // ------------------------------
    // Stimulus table
    // ------------------------------
    function automatic test_row_t make_row(
        input logic pg, input logic wp, input logic fl, input logic [31:0] addr,
        input logic [1:0] cpl, input logic rmw, input logic flt, input logic [15:0] err,
        input logic [3:0] reads, input logic [31:0] phys
    );
        test_row_t r;
        r.paging  = pg;
        r.wp      = wp;
        r.flush   = fl;
        r.address = addr;
        r.cpl     = cpl;
        r.rmw     = rmw;
        r.fault   = flt;
        r.error   = err;
        r.reads   = reads;
        r.phys    = phys;
        return r;
    endfunction

    task automatic load_rows();
        // paging wp flush address cpl rmw, then fault error reads phys
        rows[0]  = make_row(1'b0, 1'b0, 1'b0, 32'h0012_3458, 2'd0, 1'b0,
                            1'b0, 16'h0, 4'd1, 32'h0012_3458);
        // Miss walks PDE and PTE, then the data read
        rows[1]  = make_row(1'b1, 1'b0, 1'b0, 32'h0000_5abc, 2'd3, 1'b0,
                            1'b0, 16'h0, 4'd3, 32'h0010_0abc);
        rows[2]  = make_row(1'b1, 1'b0, 1'b0, 32'h0000_5010, 2'd3, 1'b0,
                            1'b0, 16'h0, 4'd1, 32'h0010_0010);
        // User read of a supervisor PTE
        rows[3]  = make_row(1'b1, 1'b0, 1'b0, 32'h0000_7123, 2'd3, 1'b0,
                            1'b1, 16'h5, 4'd2, 32'h0);
        // WP blocks the supervisor rmw on a read-only page
        rows[4]  = make_row(1'b1, 1'b1, 1'b0, 32'h0000_6200, 2'd0, 1'b1,
                            1'b1, 16'h3, 4'd2, 32'h0);
        rows[5]  = make_row(1'b1, 1'b0, 1'b0, 32'h0000_6200, 2'd0, 1'b1,
                            1'b0, 16'h0, 4'd3, 32'h0010_1200);
        // Denied from the TLB without memory traffic
        rows[6]  = make_row(1'b1, 1'b0, 1'b0, 32'h0000_6204, 2'd3, 1'b1,
                            1'b1, 16'h7, 4'd0, 32'h0);
        // Missing PDE stops after one read
        rows[7]  = make_row(1'b1, 1'b0, 1'b0, 32'h0080_1000, 2'd0, 1'b0,
                            1'b1, 16'h0, 4'd1, 32'h0);
        rows[8]  = make_row(1'b1, 1'b0, 1'b0, 32'h0080_1000, 2'd3, 1'b0,
                            1'b1, 16'h4, 4'd1, 32'h0);
        // Supervisor PDE over a user PTE
        rows[9]  = make_row(1'b1, 1'b0, 1'b0, 32'h0040_3010, 2'd0, 1'b0,
                            1'b0, 16'h0, 4'd3, 32'h0020_0010);
        rows[10] = make_row(1'b1, 1'b0, 1'b0, 32'h0040_3ffc, 2'd3, 1'b0,
                            1'b1, 16'h5, 4'd0, 32'h0);
        // Flushed page needs a full walk again
        rows[11] = make_row(1'b1, 1'b0, 1'b1, 32'h0000_5abc, 2'd3, 1'b0,
                            1'b0, 16'h0, 4'd3, 32'h0010_0abc);
        rows[12] = make_row(1'b1, 1'b0, 1'b0, 32'h0000_5ff8, 2'd3, 1'b0,
                            1'b0, 16'h0, 4'd1, 32'h0010_0ff8);
        rows[13] = make_row(1'b0, 1'b0, 1'b0, 32'h0000_5abc, 2'd0, 1'b1,
                            1'b0, 16'h0, 4'd1, 32'h0000_5abc);
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // Sampled in the read_done cycle
    task automatic check_outcome(input test_row_t row, input logic [31:0] reads_before);
        logic [31:0] reads_made;
        reads_made = read_count - reads_before;
        check_value("read_page_fault", 64'(read_page_fault), 64'(row.fault));
        check_value("read_count", 64'(reads_made), 64'(row.reads));
        if (row.fault) begin
            check_value("fault_address", 64'(fault_address), 64'(row.address));
            check_value("fault_error", 64'(fault_error), 64'(row.error));
        end else begin
            check_value("read_data", read_data, {row.phys, ~row.phys});
        end
    endtask

    task automatic run_row(input int index);
        test_row_t   row;
        logic [31:0] reads_before;
        int          errors_before;
        int          cycles;
        logic        seen;
        row           = rows[index];
        errors_before = error_count;
        cycles        = 0;
        seen          = 1'b0;
        // Mode bits and flush strobe one cycle ahead of the request
        @(posedge clk);
        paging        <= row.paging;
        write_protect <= row.wp;
        flush_all     <= row.flush;
        @(negedge clk);
        reads_before = read_count;
        @(posedge clk);
        flush_all    <= 1'b0;
        read_do      <= 1'b1;
        read_address <= row.address;
        read_cpl     <= row.cpl;
        read_rmw     <= row.rmw;
        while (!seen && cycles < ROW_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (read_done) begin
                seen = 1'b1;
                check_outcome(row, reads_before);
            end
        end
        @(posedge clk);
        read_do <= 1'b0;
        if (!seen) begin
            $display("Row %0d: read_done never came within %0d cycles", index, ROW_LIMIT);
            error_count++;
        end
        if (error_count != errors_before)
            rows_failed++;
        $display("Row %0d: paging %0d cpl %0d rmw %0d address %h %s", index, row.paging,
                 row.cpl, row.rmw, row.address, (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        rst_n         = 1'b0;
        paging        = 1'b0;
        write_protect = 1'b0;
        cr3           = 32'h0001_0000;
        flush_all     = 1'b0;
        read_do       = 1'b0;
        read_cpl      = 2'd0;
        read_rmw      = 1'b0;
        read_address  = '0;
        load_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // Completion, fault and memory request all idle out of reset
        @(negedge clk);
        check_value("read_done", 64'(read_done), 64'd0);
        check_value("read_page_fault", 64'(read_page_fault), 64'd0);
        check_value("mem_read_do", 64'(mem_read_do), 64'd0);
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("Rows run: %0d, failed: %0d, errors: %0d", NUM_ROWS, rows_failed, error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- test/tb_page_memory.sv
// Fixed page layout with the directory at 0x0001_0000; serves one read at a time, 1 to 3 cycles
module tb_page_memory (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read_do,
    input  logic [31:0] mem_read_address,
    output logic        mem_read_done,
    output logic [63:0] mem_read_data,
    output logic [31:0] read_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // Region 1 is the directory, regions 2 and 3 page tables
    logic [31:0] table_mem [4][1024];
    logic        busy;
    logic [1:0]  wait_cnt;
    logic [31:0] addr_r;
    logic [7:0]  lfsr_state;
    logic [1:0]  pick;

    // 8-bit Fibonacci LFSR with taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Table words in the low half, elsewhere the address and its inverse
    function automatic logic [63:0] word_at(input logic [31:0] addr);
        if (addr[31:18] == '0 && addr[17:16] != 2'b00 && addr[15:12] == 4'h0)
            return {32'h0, table_mem[addr[17:16]][addr[11:2]]};
        return {addr, ~addr};
    endfunction

    // ------------------------------
    // Page tables
    // ------------------------------
    initial begin
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 1024; i++)
                table_mem[r][i] = '0;
        end
        // PDE 0 user writable, PDE 1 supervisor only, PDE 2 missing
        table_mem[1][0] = 32'h0002_0007;
        table_mem[1][1] = 32'h0003_0003;
        // Table 0 holds user rw, user read-only and supervisor rw pages
        table_mem[2][5] = 32'h0010_0007;
        table_mem[2][6] = 32'h0010_1005;
        table_mem[2][7] = 32'h0010_2003;
        // Table 1 holds a user rw page narrowed by its PDE
        table_mem[3][3] = 32'h0020_0007;
    end

    // ------------------------------
    // Read port
    // ------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_read_done <= 1'b0;
            mem_read_data <= '0;
            read_count    <= '0;
            busy          <= 1'b0;
            wait_cnt      <= 2'd1;
            addr_r        <= '0;
            lfsr_state    = 8'd82;
        end else begin
            mem_read_done <= 1'b0;
            // Skip the cycle after done since the address may still be stale
            if (!mem_read_done && !busy && mem_read_do) begin
                lfsr_state = lfsr_step(lfsr_state);
                pick[0]    = lfsr_state[0];
                lfsr_state = lfsr_step(lfsr_state);
                pick[1]    = lfsr_state[0];
                wait_cnt   <= 2'd1 + (pick % 2'd3);
                addr_r     <= mem_read_address;
                busy       <= 1'b1;
            end else if (busy) begin
                if (wait_cnt == 2'd1) begin
                    mem_read_done <= 1'b1;
                    mem_read_data <= word_at(addr_r);
                    read_count    <= read_count + 32'd1;
                    busy          <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

//--- design/mmu_top.sv
// Read-only paging unit; read_data is only meaningful in the read_done cycle of a clean read
module mmu_top #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    paging,
    input  logic                    write_protect,
    input  paging_pkg::page_entry_t cr3,
    input  logic                    flush_all,
    input  logic                    read_do,
    input  logic [1:0]              read_cpl,
    input  logic                    read_rmw,
    input  paging_pkg::lin_addr_t   read_address,
    output logic                    read_done,
    output logic                    read_page_fault,
    output logic [63:0]             read_data,
    output paging_pkg::lin_addr_t   fault_address,
    output paging_pkg::pf_error_t   fault_error,
    output logic                    mem_read_do,
    output paging_pkg::phys_addr_t  mem_read_address,
    input  logic                    mem_read_done,
    input  logic [63:0]             mem_read_data
);

    // ------------------------------
    // Internal nets
    // ------------------------------
    paging_pkg::lin_addr_t  lookup_linear;
    logic                   hit;
    paging_pkg::frame_t     hit_frame;
    logic                   hit_rw;
    logic                   hit_su;

    logic                   fill_do;
    paging_pkg::lin_addr_t  fill_linear;
    paging_pkg::frame_t     fill_frame;
    logic                   fill_rw;
    logic                   fill_su;
    logic                   flush_do;

    logic                   walk_start;
    paging_pkg::lin_addr_t  walk_linear;
    logic                   walk_mem_do;
    paging_pkg::phys_addr_t walk_mem_address;
    logic                   walk_done;
    logic                   walk_present;
    paging_pkg::frame_t     walk_frame;
    logic                   walk_rw;
    logic                   walk_su;

    // Data passes straight from memory
    assign read_data = mem_read_data;

    tlb_cache #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_linear (lookup_linear),
        .fill_do       (fill_do),
        .fill_linear   (fill_linear),
        .fill_frame    (fill_frame),
        .fill_rw       (fill_rw),
        .fill_su       (fill_su),
        .flush_do      (flush_do),
        .hit           (hit),
        .hit_frame     (hit_frame),
        .hit_rw        (hit_rw),
        .hit_su        (hit_su)
    );

    // Walker reads on the shared port through the controller
    page_walker u_walker (
        .clk              (clk),
        .rst_n            (rst_n),
        .walk_start       (walk_start),
        .walk_linear      (walk_linear),
        .cr3              (cr3),
        .mem_read_done    (mem_read_done),
        .mem_read_data    (mem_read_data),
        .walk_mem_do      (walk_mem_do),
        .walk_mem_address (walk_mem_address),
        .walk_done        (walk_done),
        .walk_present     (walk_present),
        .walk_frame       (walk_frame),
        .walk_rw          (walk_rw),
        .walk_su          (walk_su)
    );

    access_control u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .paging           (paging),
        .write_protect    (write_protect),
        .flush_all        (flush_all),
        .read_do          (read_do),
        .read_cpl         (read_cpl),
        .read_rmw         (read_rmw),
        .read_address     (read_address),
        .hit              (hit),
        .hit_frame        (hit_frame),
        .hit_rw           (hit_rw),
        .hit_su           (hit_su),
        .walk_mem_do      (walk_mem_do),
        .walk_mem_address (walk_mem_address),
        .walk_done        (walk_done),
        .walk_present     (walk_present),
        .walk_frame       (walk_frame),
        .walk_rw          (walk_rw),
        .walk_su          (walk_su),
        .mem_read_done    (mem_read_done),
        .read_done        (read_done),
        .read_page_fault  (read_page_fault),
        .fault_address    (fault_address),
        .fault_error      (fault_error),
        .lookup_linear    (lookup_linear),
        .fill_do          (fill_do),
        .fill_linear      (fill_linear),
        .fill_frame       (fill_frame),
        .fill_rw          (fill_rw),
        .fill_su          (fill_su),
        .flush_do         (flush_do),
        .walk_start       (walk_start),
        .walk_linear      (walk_linear),
        .mem_read_do      (mem_read_do),
        .mem_read_address (mem_read_address)
    );

endmodule

//--- design/access_control.sv
// One read at a time; a flush_all seen while busy is applied on the next return to idle
module access_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   paging,
    input  logic                   write_protect,
    input  logic                   flush_all,
    input  logic                   read_do,
    input  logic [1:0]             read_cpl,
    input  logic                   read_rmw,
    input  paging_pkg::lin_addr_t  read_address,
    input  logic                   hit,
    input  paging_pkg::frame_t     hit_frame,
    input  logic                   hit_rw,
    input  logic                   hit_su,
    input  logic                   walk_mem_do,
    input  paging_pkg::phys_addr_t walk_mem_address,
    input  logic                   walk_done,
    input  logic                   walk_present,
    input  paging_pkg::frame_t     walk_frame,
    input  logic                   walk_rw,
    input  logic                   walk_su,
    input  logic                   mem_read_done,
    output logic                   read_done,
    output logic                   read_page_fault,
    output paging_pkg::lin_addr_t  fault_address,
    output paging_pkg::pf_error_t  fault_error,
    output paging_pkg::lin_addr_t  lookup_linear,
    output logic                   fill_do,
    output paging_pkg::lin_addr_t  fill_linear,
    output paging_pkg::frame_t     fill_frame,
    output logic                   fill_rw,
    output logic                   fill_su,
    output logic                   flush_do,
    output logic                   walk_start,
    output paging_pkg::lin_addr_t  walk_linear,
    output logic                   mem_read_do,
    output paging_pkg::phys_addr_t mem_read_address
);

    // User reads need U/S; writes need R/W for users, and for supervisors under WP
    function automatic logic priv_fault(input logic user, input logic write, input logic wp,
                                        input logic e_rw, input logic e_su);
        return (user && !e_su) || (user && write && !e_rw) || (wp && !user && write && !e_rw);
    endfunction

    mmu_pkg::ctrl_state_t   state;

    // Latched request
    paging_pkg::lin_addr_t  linear_r;
    paging_pkg::phys_addr_t phys_r;
    logic                   su_r;
    logic                   rw_r;
    logic                   wp_r;
    logic                   paging_r;
    logic                   flush_pending;

    logic                   in_walk;
    logic                   entry_rw;
    logic                   entry_su;
    logic                   denied;
    logic                   take_fault;
    logic                   err_present;

    // ------------------------------
    // Privilege check
    // ------------------------------
    assign in_walk  = (state == mmu_pkg::CTRL_WALK);
    // TLB result in LOOKUP, walker result in WALK
    assign entry_rw = in_walk ? walk_rw : hit_rw;
    assign entry_su = in_walk ? walk_su : hit_su;
    assign denied   = priv_fault(su_r, rw_r, wp_r, entry_rw, entry_su);

    assign take_fault =
        (state == mmu_pkg::CTRL_LOOKUP && paging_r && hit && denied) ||
        (in_walk && walk_done && (!walk_present || denied));
    // Not-present only possible from a walk
    assign err_present = in_walk ? walk_present : 1'b1;

    // TLB and walker side
    assign lookup_linear = linear_r;
    assign walk_linear   = linear_r;
    assign walk_start    = (state == mmu_pkg::CTRL_LOOKUP) && paging_r && !hit;
    assign fill_do       = in_walk && walk_done && walk_present && !denied;
    assign fill_linear   = linear_r;
    assign fill_frame    = walk_frame;
    assign fill_rw       = walk_rw;
    assign fill_su       = walk_su;
    assign flush_do      = (state == mmu_pkg::CTRL_IDLE) && (flush_all || flush_pending);

    // Memory port owned by the walker while walking
    assign mem_read_do      = in_walk ? walk_mem_do : (state == mmu_pkg::CTRL_DATA_READ);
    assign mem_read_address = in_walk ? walk_mem_address : phys_r;

    assign read_done = (state == mmu_pkg::CTRL_DATA_READ && mem_read_done) ||
                       (state == mmu_pkg::CTRL_DONE && read_page_fault);

    // ------------------------------
    // Sequencing FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mmu_pkg::CTRL_IDLE;
        end else begin
            case (state)
                mmu_pkg::CTRL_IDLE: begin
                    if (read_do)
                        state <= mmu_pkg::CTRL_LOOKUP;
                end
                mmu_pkg::CTRL_LOOKUP: begin
                    if (take_fault)
                        state <= mmu_pkg::CTRL_DONE;
                    else if (paging_r && !hit)
                        state <= mmu_pkg::CTRL_WALK;
                    else
                        state <= mmu_pkg::CTRL_DATA_READ;
                end
                mmu_pkg::CTRL_WALK: begin
                    if (walk_done)
                        state <= take_fault ? mmu_pkg::CTRL_DONE : mmu_pkg::CTRL_DATA_READ;
                end
                mmu_pkg::CTRL_DATA_READ: begin
                    if (mem_read_done)
                        state <= mmu_pkg::CTRL_DONE;
                end
                // Gap cycle lets the requester drop read_do
                default: state <= mmu_pkg::CTRL_IDLE;
            endcase
        end
    end

    // Fault report and deferred flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_page_fault <= 1'b0;
            fault_address   <= '0;
            fault_error     <= '0;
            flush_pending   <= 1'b0;
        end else begin
            if (take_fault) begin
                read_page_fault <= 1'b1;
                fault_address   <= linear_r;
                fault_error     <= paging_pkg::make_error(err_present, rw_r, su_r);
            end else if (state == mmu_pkg::CTRL_DONE) begin
                read_page_fault <= 1'b0;
            end
            if (state == mmu_pkg::CTRL_IDLE)
                flush_pending <= 1'b0;
            else if (flush_all)
                flush_pending <= 1'b1;
        end
    end

    // Request latch and physical address
    always_ff @(posedge clk) begin
        if (state == mmu_pkg::CTRL_IDLE && read_do) begin
            linear_r <= read_address;
            su_r     <= (read_cpl == paging_pkg::USER_CPL);
            rw_r     <= read_rmw;
            wp_r     <= write_protect;
            paging_r <= paging;
        end
        // Identity map when paging is off
        if (state == mmu_pkg::CTRL_LOOKUP)
            phys_r <= paging_r ? {hit_frame, linear_r[paging_pkg::OFFSET_BITS-1:0]} : linear_r;
        if (in_walk)
            phys_r <= {walk_frame, linear_r[paging_pkg::OFFSET_BITS-1:0]};
    end

    // One completion per request
    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n) read_done |=> !read_done
    );

endmodule

//--- design/page_walker.sv
// Entries come from the low 32 bits of each memory word; cr3 must stay stable during a walk
module page_walker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    walk_start,
    input  paging_pkg::lin_addr_t   walk_linear,
    input  paging_pkg::page_entry_t cr3,
    input  logic                    mem_read_done,
    input  logic [63:0]             mem_read_data,
    output logic                    walk_mem_do,
    output paging_pkg::phys_addr_t  walk_mem_address,
    output logic                    walk_done,
    output logic                    walk_present,
    output paging_pkg::frame_t      walk_frame,
    output logic                    walk_rw,
    output logic                    walk_su
);

    mmu_pkg::walk_state_t    state;
    paging_pkg::lin_addr_t   linear_r;
    paging_pkg::page_entry_t entry;

    // Table base first, then page frame once the PTE is in
    paging_pkg::frame_t      base_frame;
    logic                    present_r;
    logic                    rw_acc;
    logic                    su_acc;
    logic [9:0]              index;

    assign entry = mem_read_data[31:0];

    // ------------------------------
    // Memory request
    // ------------------------------
    // Directory index for the PDE, table index for the PTE
    assign index = (state == mmu_pkg::WALK_PDE_READ) ?
                   linear_r[paging_pkg::DIR_MSB:paging_pkg::DIR_LSB] :
                   linear_r[paging_pkg::TABLE_MSB:paging_pkg::TABLE_LSB];

    assign walk_mem_do      = (state == mmu_pkg::WALK_PDE_READ) ||
                              (state == mmu_pkg::WALK_PTE_READ);
    assign walk_mem_address = {base_frame, index, 2'b00};

    // Result valid for the FINISH cycle
    assign walk_done    = (state == mmu_pkg::WALK_FINISH);
    assign walk_present = present_r;
    assign walk_frame   = base_frame;
    assign walk_rw      = rw_acc;
    assign walk_su      = su_acc;

    // ------------------------------
    // Walk FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mmu_pkg::WALK_IDLE;
        end else begin
            case (state)
                mmu_pkg::WALK_IDLE: begin
                    if (walk_start)
                        state <= mmu_pkg::WALK_PDE_READ;
                end
                mmu_pkg::WALK_PDE_READ: begin
                    // Missing PDE ends the walk early
                    if (mem_read_done)
                        state <= entry[paging_pkg::PRESENT_BIT] ?
                                 mmu_pkg::WALK_PTE_READ : mmu_pkg::WALK_FINISH;
                end
                mmu_pkg::WALK_PTE_READ: begin
                    if (mem_read_done)
                        state <= mmu_pkg::WALK_FINISH;
                end
                default: state <= mmu_pkg::WALK_IDLE;
            endcase
        end
    end

    // Walk data path
    always_ff @(posedge clk) begin
        if (state == mmu_pkg::WALK_IDLE && walk_start) begin
            linear_r   <= walk_linear;
            base_frame <= cr3[31:paging_pkg::OFFSET_BITS];
        end
        if (mem_read_done && walk_mem_do) begin
            base_frame <= entry[31:paging_pkg::OFFSET_BITS];
            present_r  <= entry[paging_pkg::PRESENT_BIT];
            // PDE seeds the permissions, PTE narrows them
            if (state == mmu_pkg::WALK_PDE_READ) begin
                rw_acc <= entry[paging_pkg::RW_BIT];
                su_acc <= entry[paging_pkg::US_BIT];
            end else begin
                rw_acc <= rw_acc & entry[paging_pkg::RW_BIT];
                su_acc <= su_acc & entry[paging_pkg::US_BIT];
            end
        end
    end

    // Only one walk in flight
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) walk_start |-> state == mmu_pkg::WALK_IDLE
    );

endmodule

//--- design/tlb_cache.sv
// TLB_ENTRIES must be a power of two from 2 to 16; fill and flush may not coincide
module tlb_cache #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  paging_pkg::lin_addr_t lookup_linear,
    input  logic                 fill_do,
    input  paging_pkg::lin_addr_t fill_linear,
    input  paging_pkg::frame_t   fill_frame,
    input  logic                 fill_rw,
    input  logic                 fill_su,
    input  logic                 flush_do,
    output logic                 hit,
    output paging_pkg::frame_t   hit_frame,
    output logic                 hit_rw,
    output logic                 hit_su
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);
    localparam int TAG_W = paging_pkg::DIR_MSB - paging_pkg::TABLE_LSB + 1;

    // ------------------------------
    // Entry storage
    // ------------------------------
    logic [TLB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]       tag [TLB_ENTRIES];
    paging_pkg::frame_t     frame [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] rw_bits;
    logic [TLB_ENTRIES-1:0] su_bits;

    // Round-robin victim pointer
    logic [IDX_W-1:0]       rr_ptr;

    logic [TAG_W-1:0]       lookup_tag;
    logic [TAG_W-1:0]       fill_tag;

    // Linear page number is the tag
    assign lookup_tag = lookup_linear[paging_pkg::DIR_MSB:paging_pkg::TABLE_LSB];
    assign fill_tag   = fill_linear[paging_pkg::DIR_MSB:paging_pkg::TABLE_LSB];

    // Parallel compare over all entries
    always_comb begin
        hit       = 1'b0;
        hit_frame = '0;
        hit_rw    = 1'b0;
        hit_su    = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (valid[i] && tag[i] == lookup_tag) begin
                hit       = 1'b1;
                hit_frame = frame[i];
                hit_rw    = rw_bits[i];
                hit_su    = su_bits[i];
            end
        end
    end

    // Valid bits and victim pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (flush_do) begin
            valid  <= '0;
        end else if (fill_do) begin
            valid[rr_ptr] <= 1'b1;
            rr_ptr        <= rr_ptr + 1'b1;
        end
    end

    // Payload written at the victim slot
    always_ff @(posedge clk) begin
        if (fill_do) begin
            tag[rr_ptr]     <= fill_tag;
            frame[rr_ptr]   <= fill_frame;
            rw_bits[rr_ptr] <= fill_rw;
            su_bits[rr_ptr] <= fill_su;
        end
    end

    // Controller holds a flush back while a walk can still fill
    a_no_fill_with_flush: assert property (
        @(posedge clk) disable iff (!rst_n) !(fill_do && flush_do)
    );

endmodule

//--- design/mmu_pkg.sv
// State encodings only; labels carry a CTRL_ or WALK_ prefix for their machine
package mmu_pkg;

    // Access controller sequencing
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_WALK,
        CTRL_DATA_READ,
        CTRL_DONE
    } ctrl_state_t;

    // Two-level table walk
    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_PDE_READ,
        WALK_PTE_READ,
        WALK_FINISH
    } walk_state_t;

endpackage

//--- design/paging_pkg.sv
// Assumes 32-bit non-PAE paging with 4 KiB pages only; PSE large pages are not decoded
package paging_pkg;

    // ------------------------------
    // Address and entry widths
    // ------------------------------
    typedef logic [31:0] lin_addr_t;
    typedef logic [31:0] phys_addr_t;
    typedef logic [31:0] page_entry_t;
    typedef logic [19:0] frame_t;
    typedef logic [15:0] pf_error_t;

    // Entry bit positions shared by PDE, PTE and the error code
    localparam int PRESENT_BIT = 0;
    localparam int RW_BIT      = 1;
    localparam int US_BIT      = 2;

    // Linear address fields
    localparam int DIR_MSB     = 31;
    localparam int DIR_LSB     = 22;
    localparam int TABLE_MSB   = 21;
    localparam int TABLE_LSB   = 12;
    localparam int OFFSET_BITS = 12;

    // CPL 3 counts as user, all others as supervisor
    localparam logic [1:0] USER_CPL = 2'd3;

    // ------------------------------
    // Page fault error code
    // ------------------------------
    // Upper bits stay zero
    function automatic pf_error_t make_error(
        input logic present,
        input logic write,
        input logic user
    );
        pf_error_t err;
        err              = '0;
        err[PRESENT_BIT] = present;
        err[RW_BIT]      = write;
        err[US_BIT]      = user;
        return err;
    endfunction

endpackage
